// File: verilog/z80_params.svh
/* z80 load slice: bus widths and start address. */
`ifndef Z80_PARAMS_SVH
`define Z80_PARAMS_SVH

// address bus width in bits.
`define Z80_ADDR_W 16

// data bus width in bits.
`define Z80_DATA_W 8

`define Z80_RESET_PC 0 // first fetch address.

`endif

// File: verilog/z80_regs_pkg.sv
/* z80 load slice: register codes and datapath widths. */
`include "z80_params.svh"

package z80_regs_pkg;

    typedef logic [`Z80_DATA_W-1:0] byte_t;
    typedef logic [`Z80_ADDR_W-1:0] addr_t;

    // register field as it appears in the ddd and sss opcode bits.
    typedef enum logic [2:0] {
        REG_B   = 3'd0,
        REG_C   = 3'd1,
        REG_D   = 3'd2,
        REG_E   = 3'd3,
        REG_H   = 3'd4,
        REG_L   = 3'd5,
        REG_MEM = 3'd6, // (hl) operand.
        REG_A   = 3'd7
    } reg_code_t;

endpackage

// File: verilog/z80_ctrl_pkg.sv
/* z80 load slice: T-state, machine-cycle and address-select types
   plus the opcode field codes the decoder looks for. */
package z80_ctrl_pkg;

    typedef enum logic [1:0] {
        T1 = 2'd0,
        T2 = 2'd1,
        T3 = 2'd2,
        T4 = 2'd3
    } t_state_t;

    // machine cycles of the load group.
    typedef enum logic [1:0] {
        M_FETCH  = 2'd0,
        M_MEM_RD = 2'd1,
        M_MEM_WR = 2'd2,
        M_HALT   = 2'd3
    } m_cycle_t;

    typedef enum logic {
        ADDR_PC = 1'b0,
        ADDR_HL = 1'b1
    } addr_sel_t;

    // x field, opcode bits 7:6.
    localparam logic [1:0] X_MISC = 2'b00;
    localparam logic [1:0] X_LD   = 2'b01;

    localparam logic [2:0] Z_LD_IMM = 3'b110; // ld r,n in the 00 group.

    // halt takes the slot of ld (hl),(hl).
    localparam logic [7:0] OP_HALT = 8'h76;

endpackage

// File: verilog/z80_ctrl_if.sv
/* z80 load slice: control strobes and datapath values shared by
   the decoder, the register file and the bus block. */
interface z80_ctrl_if import z80_regs_pkg::*, z80_ctrl_pkg::*; ();

    addr_sel_t addr_sel;
    logic      mem_rd;      // read request for the coming T-state.
    logic      mem_wr;      // write request for the coming T-state.
    logic      halt;
    logic      pc_inc;
    reg_code_t src_reg;
    reg_code_t dst_reg;
    logic      dst_load;
    logic      dst_from_bus;
    logic      opcode_load;
    byte_t     src_data;
    addr_t     hl;
    byte_t     bus_data;    // latched read byte.

    modport decode (
        output addr_sel, mem_rd, mem_wr, halt, pc_inc,
        output src_reg, dst_reg, dst_load, dst_from_bus, opcode_load,
        input  bus_data
    );

    modport exec (
        input  src_reg, dst_reg, dst_load, dst_from_bus, bus_data,
        output src_data, hl
    );

    modport bus (
        input  addr_sel, mem_rd, mem_wr, halt, pc_inc, src_data, hl,
        output bus_data
    );

endinterface

// File: verilog/z80_ld_decode.sv
/* z80 load slice T-state sequencer and load-group decoder with
   one-hot per-state strobes. */
module z80_ld_decode import z80_regs_pkg::*, z80_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  byte_t           rdata,
    z80_ctrl_if.decode      ctl
);

    t_state_t  t_st;
    t_state_t  t_nxt;
    m_cycle_t  m_cyc;
    m_cycle_t  m_nxt;
    byte_t     opcode;
    logic [1:0] op_x;
    reg_code_t op_y;
    reg_code_t op_z;
    logic [3:0] t_hot;
    logic      fetch_cyc;
    logic      rd_cyc;
    logic      wr_cyc;
    logic      is_halt;
    logic      is_ld_rr;
    logic      is_st_hl;
    logic      is_ld_hl;
    logic      is_ld_imm;

    assign op_x = opcode[7:6];
    assign op_y = reg_code_t'(opcode[5:3]);
    assign op_z = reg_code_t'(opcode[2:0]);

    assign is_halt   = (opcode == OP_HALT);
    assign is_ld_rr  = (op_x == X_LD) && (op_y != REG_MEM) && (op_z != REG_MEM);
    assign is_st_hl  = (op_x == X_LD) && (op_y == REG_MEM) && !is_halt;
    assign is_ld_hl  = (op_x == X_LD) && (op_z == REG_MEM) && !is_halt;
    assign is_ld_imm = (op_x == X_MISC) && (op_z == Z_LD_IMM) && (op_y != REG_MEM);

    always_comb begin
        m_nxt = m_cyc;
        t_nxt = t_st;
        case (m_cyc)
            M_FETCH: begin
                if (t_st == T4) begin
                    t_nxt = T1;
                    if (is_halt)
                        m_nxt = M_HALT;
                    else if (is_st_hl)
                        m_nxt = M_MEM_WR;
                    else if (is_ld_hl || is_ld_imm)
                        m_nxt = M_MEM_RD;
                    else
                        m_nxt = M_FETCH;
                end else begin
                    t_nxt = t_state_t'(t_st + 2'd1);
                end
            end
            M_MEM_RD, M_MEM_WR: begin
                if (t_st == T3) begin // memory cycles are three states.
                    m_nxt = M_FETCH;
                    t_nxt = T1;
                end else begin
                    t_nxt = t_state_t'(t_st + 2'd1);
                end
            end
            default: begin
                m_nxt = M_HALT; // parked until reset.
                t_nxt = T1;
            end
        endcase
    end

    // reset parks at the tail of a no-op so the first edge enters fetch T1.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_cyc  <= M_FETCH;
            t_st   <= T4;
            opcode <= '0;
        end else begin
            m_cyc <= m_nxt;
            t_st  <= t_nxt;
            if (ctl.opcode_load)
                opcode <= ctl.bus_data;
        end
    end

    // bus pins are registered, so requests look one state ahead.
    assign ctl.mem_rd = ((m_nxt == M_FETCH) || (m_nxt == M_MEM_RD)) && (t_nxt != T4);
    assign ctl.mem_wr = (m_nxt == M_MEM_WR) && (t_nxt == T2);
    assign ctl.halt   = (m_nxt == M_HALT);

    assign t_hot     = 4'b0001 << t_st;
    assign fetch_cyc = (m_cyc == M_FETCH);
    assign rd_cyc    = (m_cyc == M_MEM_RD);
    assign wr_cyc    = (m_cyc == M_MEM_WR);

    assign ctl.opcode_load  = fetch_cyc & t_hot[2];
    assign ctl.pc_inc       = (fetch_cyc & t_hot[2]) | (rd_cyc & t_hot[2] & is_ld_imm);
    assign ctl.dst_load     = (fetch_cyc & t_hot[3] & is_ld_rr) | (rd_cyc & t_hot[2]);
    assign ctl.dst_from_bus = rd_cyc;
    assign ctl.addr_sel     = (wr_cyc || (rd_cyc && is_ld_hl)) ? ADDR_HL : ADDR_PC;
    assign ctl.src_reg      = op_z;
    assign ctl.dst_reg      = op_y;

    // a write request never overlaps or directly follows a read request.
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.mem_wr |-> (!ctl.mem_rd && !$past(ctl.mem_rd)))
        else $error("write requested during or right after a read");

    // the read latch must still hold the byte at the fetch address.
    a_opcode_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.opcode_load |-> (ctl.bus_data == rdata))
        else $error("opcode latch disagrees with memory");

endmodule

// File: verilog/z80_ld_exec.sv
/* z80 load slice: register file and load data movement. */
module z80_ld_exec import z80_regs_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    z80_ctrl_if.exec  ctl
);

    byte_t r_b;
    byte_t r_c;
    byte_t r_d;
    byte_t r_e;
    byte_t r_h;
    byte_t r_l;
    byte_t r_a;
    byte_t wr_data;

    assign wr_data = ctl.dst_from_bus ? ctl.bus_data : ctl.src_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_b <= '0;
            r_c <= '0;
            r_d <= '0;
            r_e <= '0;
            r_h <= '0;
            r_l <= '0;
            r_a <= '0;
        end else if (ctl.dst_load) begin
            case (ctl.dst_reg)
                REG_B:   r_b <= wr_data;
                REG_C:   r_c <= wr_data;
                REG_D:   r_d <= wr_data;
                REG_E:   r_e <= wr_data;
                REG_H:   r_h <= wr_data;
                REG_L:   r_l <= wr_data;
                REG_A:   r_a <= wr_data;
                default: ;
            endcase
        end
    end

    // source mux, (hl) falls back to the read latch.
    always_comb begin
        case (ctl.src_reg)
            REG_B:   ctl.src_data = r_b;
            REG_C:   ctl.src_data = r_c;
            REG_D:   ctl.src_data = r_d;
            REG_E:   ctl.src_data = r_e;
            REG_H:   ctl.src_data = r_h;
            REG_L:   ctl.src_data = r_l;
            REG_A:   ctl.src_data = r_a;
            default: ctl.src_data = ctl.bus_data;
        endcase
    end

    assign ctl.hl = {r_h, r_l}; // memory pointer.

    a_no_mem_dst: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.dst_load |-> (ctl.dst_reg != REG_MEM))
        else $error("register load aimed at (hl)");

endmodule

// File: verilog/z80_bus_result.sv
/* z80 load slice: program counter, address mux, write data
   and read latch toward the memory pins. */
`include "z80_params.svh"

module z80_bus_result import z80_regs_pkg::*, z80_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    z80_ctrl_if.bus   ctl,
    input  byte_t     mem_rdata,
    output addr_t     mem_addr,
    output byte_t     mem_wdata,
    output logic      mem_rd,
    output logic      mem_wr,
    output logic      halted
);

    addr_t pc;
    byte_t wdata_q;
    logic  rd_q;
    logic  wr_q;
    logic  halt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= addr_t'(`Z80_RESET_PC);
            rd_q   <= 1'b0;
            wr_q   <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            if (ctl.pc_inc)
                pc <= pc + addr_t'(1);
            rd_q   <= ctl.mem_rd;
            wr_q   <= ctl.mem_wr;
            halt_q <= ctl.halt;
        end
    end

    // captured as the write strobe is set up.
    always_ff @(posedge clk) begin
        if (ctl.mem_wr)
            wdata_q <= ctl.src_data;
    end

    always_ff @(posedge clk) begin
        if (rd_q)
            ctl.bus_data <= mem_rdata; // last byte seen during a read.
    end

    assign mem_addr  = (ctl.addr_sel == ADDR_HL) ? ctl.hl : pc;
    assign mem_wdata = wdata_q;
    assign mem_rd    = rd_q;
    assign mem_wr    = wr_q;
    assign halted    = halt_q;

    // write strobe comes from the lookahead, address select from the current state.
    a_wr_at_hl: assert property (@(posedge clk) disable iff (!rst_n)
        wr_q |-> (ctl.addr_sel == ADDR_HL))
        else $error("memory write while address is not hl");

endmodule

// File: verilog/z80_ld_core.sv
/* z80 load slice top: decoder, register file and bus block
   tied to the memory pins. */
module z80_ld_core import z80_regs_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output addr_t mem_addr,
    input  byte_t mem_rdata,
    output byte_t mem_wdata,
    output logic  mem_wr,
    output logic  mem_rd,
    output logic  halted
);

    z80_ctrl_if ctl ();

    z80_ld_decode i_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .rdata (mem_rdata),
        .ctl   (ctl.decode)
    );

    z80_ld_exec i_exec (
        .clk   (clk),
        .rst_n (rst_n),
        .ctl   (ctl.exec)
    );

    z80_bus_result i_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (ctl.bus),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .halted    (halted)
    );

endmodule

// File: bench/tb_z80_ld_core.sv
/* testbench for the z80 load slice. it runs a program from the pattern
   file and checks memory writes, reset defaults and halt timing. */
`include "z80_params.svh"

module tb_z80_ld_core import z80_regs_pkg::*; ();

    localparam int PROG_BASE   = 'h10;
    localparam int WR_BASE     = 'h60;
    localparam int PRESET_BASE = 'h70;

    logic  clk;
    logic  rst_n;
    addr_t mem_addr;
    byte_t mem_rdata;
    byte_t mem_wdata;
    logic  mem_wr;
    logic  mem_rd;
    logic  halted;

    byte_t       mem [0:65535];
    logic [23:0] pat [0:127];

    int   prog_len;
    int   exp_wr_count;
    int   preset_count;
    int   exp_halt;
    int   wr_count = 0;
    int   checks = 0;
    int   errors = 0;
    int   cyc_idx = -1;  // 0 is the first fetch T1.
    int   rst_edges = 0;
    logic loaded = 1'b0;
    logic halt_seen = 1'b0;
    logic rd_seen = 1'b0;

    z80_ld_core i_z80_ld_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_wr    (mem_wr),
        .mem_rd    (mem_rd),
        .halted    (halted)
    );

    assign mem_rdata = mem[mem_addr]; // asynchronous read.

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n)
            cyc_idx <= cyc_idx + 1;
        else
            rst_edges <= rst_edges + 1;
    end

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst_n && rst_edges > 0) begin
            check_value("halted", 32'(0), 32'(halted));
            check_value("mem_rd", 32'(0), 32'(mem_rd));
            check_value("mem_wr", 32'(0), 32'(mem_wr));
        end else if (rst_n && cyc_idx >= 0) begin
            if (mem_rd && !rd_seen) begin
                rd_seen = 1'b1;
                check_value("mem_addr", 32'(`Z80_RESET_PC), 32'(mem_addr));
                check_value("first read cycle", 32'(0), 32'(cyc_idx));
            end
            if (mem_wr) begin
                if (wr_count < exp_wr_count) begin
                    check_value("mem_addr", 32'(pat[7'(WR_BASE + wr_count)][23:8]),
                                32'(mem_addr));
                    check_value("mem_wdata", 32'(pat[7'(WR_BASE + wr_count)][7:0]),
                                32'(mem_wdata));
                end else begin
                    errors++;
                    $display("unexpected memory write at time %0t to address %h",
                             $time, mem_addr);
                end
                mem[mem_addr] = mem_wdata;
                wr_count++;
            end
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                check_value("halted rise cycle", 32'(exp_halt), 32'(cyc_idx));
            end
            if (halt_seen && !halted) begin
                errors++;
                $display("halted dropped again at time %0t", $time);
            end
            if (halt_seen && (mem_rd || mem_wr)) begin
                errors++;
                $display("memory strobe active after halt at time %0t", $time);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        $readmemh("bench/ld_patterns.txt", pat);
        prog_len     = int'(pat[0]);
        exp_wr_count = int'(pat[1]);
        preset_count = int'(pat[2]);
        exp_halt     = int'(pat[3]);
        for (int i = 0; i < 65536; i++)
            mem[addr_t'(i)] = i[15:8] ^ i[7:0] ^ 8'h5c;
        for (int i = 0; i < prog_len; i++)
            mem[addr_t'(`Z80_RESET_PC + i)] = pat[7'(PROG_BASE + i)][7:0];
        for (int i = 0; i < preset_count; i++)
            mem[pat[7'(PRESET_BASE + i)][23:8]] = pat[7'(PRESET_BASE + i)][7:0];
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;

        while (!halt_seen)
            @(posedge clk);
        repeat (8) @(posedge clk); // bus must stay quiet while halted.
        check_value("write count", 32'(exp_wr_count), 32'(wr_count));

        $display("checks=%0d errors=%0d writes=%0d", checks, errors, wr_count);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog sized from the expected halt cycle.
    initial begin
        wait (loaded);
        repeat (exp_halt + 50) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", exp_halt + 50);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/z80_regs_pkg.sv
verilog/z80_ctrl_pkg.sv
verilog/z80_ctrl_if.sv
verilog/z80_ld_decode.sv
verilog/z80_ld_exec.sv
verilog/z80_bus_result.sv
verilog/z80_ld_core.sv
bench/tb_z80_ld_core.sv

// File: Makefile
.PHONY: run check clean

obj_dir/Vtb_z80_ld_core: flist.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --timing --assert -f flist.f --top-module tb_z80_ld_core \
		-o Vtb_z80_ld_core

run: obj_dir/Vtb_z80_ld_core bench/ld_patterns.txt
	./obj_dir/Vtb_z80_ld_core > sim.log
	cat sim.log
	grep -qx "STATUS: PASS" sim.log

check:
	grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/ld_patterns.txt
// @00 header: program byte count, write count, preset count, expected halt cycle
// @10 program bytes, @60 expected writes {addr,data}, @70 memory presets {addr,data}
@00
22 0a 1 9f
@10
06 11 0e 22 16 33 1e 44   // ld b,n  ld c,n  ld d,n  ld e,n
3e 5a 26 80 2e 10         // ld a,n  ld h,n  ld l,n
70 71 72 73               // store b c d e at 8010
2e 11 74 75 77            // l = 11, store h l a
47 59 70 73               // ld b,a  ld e,c, store b e
2e 20 56 2e 21 72         // ld d,(8020), store d at 8021
76                        // halt
@60
801011
801022
801033
801044
801180
801111
80115a
80115a
801122
8021c3
@70
8020c3
